//--- src/branch_pkg.sv
// Branch stage shared definitions
`default_nettype none

package branch_pkg;

    //////////////////////////////////////////////////
    // Sizing
    //////////////////////////////////////////////////

    // Data and address width
    localparam int XLEN = 32;

    // Return stack entries and pointer width
    localparam int RAS_DEPTH = 4;
    localparam int RAS_PTR_W = 2;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    // Branch operation as presented by decode
    typedef enum logic [2:0] {
        BR_EQ   = 3'd0,
        BR_NE   = 3'd1,
        BR_LT   = 3'd2,
        BR_GE   = 3'd3,
        BR_LTU  = 3'd4,
        BR_GEU  = 3'd5,
        BR_JAL  = 3'd6,
        BR_JALR = 3'd7
    } branch_op_e;

    // Resolution controller states
    typedef enum logic [0:0] {
        CTRL_IDLE = 1'b0,
        CTRL_WAIT = 1'b1
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- src/branch_comparator.sv
// Branch condition compare
`default_nettype none

module branch_comparator
    import branch_pkg::*;
(
    input  branch_op_e             op,
    input  logic       [XLEN-1:0]  rs1,
    input  logic       [XLEN-1:0]  rs2,
    output logic                   cond_taken
);

    logic              use_signed;
    logic signed [XLEN:0] rs1_ext;
    logic signed [XLEN:0] rs2_ext;
    logic              equal;
    logic              less_than;

    // One compare serves both signed and unsigned forms
    assign use_signed = (op == BR_LT) || (op == BR_GE);
    assign rs1_ext    = {use_signed & rs1[XLEN-1], rs1};
    assign rs2_ext    = {use_signed & rs2[XLEN-1], rs2};

    assign equal     = (rs1 == rs2);
    assign less_than = (rs1_ext < rs2_ext);

    always_comb begin
        case (op)
            BR_EQ:   cond_taken = equal;
            BR_NE:   cond_taken = ~equal;
            BR_LT,
            BR_LTU:  cond_taken = less_than;
            BR_GE,
            BR_GEU:  cond_taken = ~less_than;
            default: cond_taken = 1'b1;   // JAL and JALR
        endcase
    end

endmodule

`default_nettype wire

//--- src/branch_target_calc.sv
// Branch target and fall-through address
`default_nettype none

module branch_target_calc
    import branch_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   capture,
    input  branch_op_e             op,
    input  logic       [31:0]      instr,
    input  logic       [XLEN-1:0]  dec_pc,
    input  logic       [XLEN-1:0]  rs1,
    output logic       [XLEN-1:0]  target_pc,
    output logic       [XLEN-1:0]  fallthrough_pc
);

    logic [20:0]      j_imm;
    logic [11:0]      i_imm;
    logic [12:0]      b_imm;
    logic [XLEN-1:0]  offset;
    logic [XLEN-1:0]  base;
    logic [XLEN-1:0]  target_sum;

    //////////////////////////////////////////////////
    // Immediate extraction
    //////////////////////////////////////////////////

    assign j_imm = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign i_imm = instr[31:20];
    assign b_imm = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // Sign extend the format selected by the opcode
    always_comb begin
        case (op)
            BR_JAL:  offset = XLEN'(signed'(j_imm));
            BR_JALR: offset = XLEN'(signed'(i_imm));
            default: offset = XLEN'(signed'(b_imm));
        endcase
    end

    // JALR is register relative, the rest are PC relative
    assign base       = (op == BR_JALR) ? rs1 : dec_pc;
    assign target_sum = base + offset;

    //////////////////////////////////////////////////
    // Registered addresses
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            target_pc      <= '0;
            fallthrough_pc <= '0;
        end else if (capture) begin
            target_pc      <= {target_sum[XLEN-1:1], 1'b0};
            fallthrough_pc <= dec_pc + XLEN'(4);
        end
    end

endmodule

`default_nettype wire

//--- src/branch_resolve_ctrl.sv
// Branch resolution controller
`default_nettype none

module branch_resolve_ctrl
    import branch_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue,
    input  branch_op_e             op,
    input  logic                   cond_taken,
    input  logic                   is_call,
    input  logic                   is_return,
    input  logic                   predicted_taken,
    input  logic                   dec_pc_valid,
    input  logic       [XLEN-1:0]  dec_pc,
    input  logic       [XLEN-1:0]  target_pc,
    input  logic       [XLEN-1:0]  fallthrough_pc,
    output logic                   capture,
    output logic                   resolve,
    output logic                   taken,
    output logic                   flush,
    output logic                   ras_push,
    output logic                   ras_pop
);

    ctrl_state_e      state;
    ctrl_state_e      state_next;
    logic             taken_r;
    logic             predicted_r;
    logic [XLEN-1:0]  expected_pc;
    logic             pc_mismatch;

    // Issue is only accepted while no branch is pending
    assign capture = issue && (state == CTRL_IDLE);
    assign resolve = dec_pc_valid && (state == CTRL_WAIT);

    //////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            CTRL_IDLE: if (issue)        state_next = CTRL_WAIT;
            CTRL_WAIT: if (dec_pc_valid) state_next = CTRL_IDLE;
            default:                     state_next = CTRL_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CTRL_IDLE;
        end else begin
            state <= state_next;
        end
    end

    //////////////////////////////////////////////////
    // Outcome capture and stack requests
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            taken_r     <= 1'b0;
            predicted_r <= 1'b0;
            ras_push    <= 1'b0;
            ras_pop     <= 1'b0;
        end else begin
            if (capture) begin
                // Jumps resolve taken whatever the compare says
                taken_r     <= cond_taken || (op == BR_JAL) || (op == BR_JALR);
                predicted_r <= predicted_taken;
            end
            // Stack updates land one cycle after capture
            ras_push <= capture && is_call;
            ras_pop  <= capture && is_return;
        end
    end

    //////////////////////////////////////////////////
    // Mispredict check
    //////////////////////////////////////////////////

    assign taken       = taken_r && (state == CTRL_WAIT);
    assign expected_pc = taken_r ? target_pc : fallthrough_pc;

    // Bit 0 never takes part in the address check
    assign pc_mismatch = (dec_pc[XLEN-1:1] != expected_pc[XLEN-1:1]);
    assign flush       = resolve && ((predicted_r != taken_r) || pc_mismatch);

endmodule

`default_nettype wire

//--- src/return_addr_stack.sv
// Return address stack
`default_nettype none

module return_addr_stack
    import branch_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  logic              pop,
    input  logic [XLEN-1:0]   push_addr,
    output logic [XLEN-1:0]   top_addr,
    output logic              not_empty
);

    logic [XLEN-1:0]       entries [RAS_DEPTH];
    logic [RAS_PTR_W-1:0]  ptr;
    logic [RAS_PTR_W:0]    count;
    logic                  full;

    assign full      = (count == (RAS_PTR_W+1)'(RAS_DEPTH));
    assign not_empty = (count != '0);
    assign top_addr  = entries[ptr];

    // Pointer and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr   <= '0;
            count <= '0;
        end else if (push && pop) begin
            // Top is replaced, an empty stack gains one entry
            if (!not_empty) count <= count + 1'b1;
        end else if (push) begin
            ptr <= ptr + 1'b1;
            // Oldest entry is overwritten once full
            if (!full) count <= count + 1'b1;
        end else if (pop && not_empty) begin
            ptr   <= ptr - 1'b1;
            count <= count - 1'b1;
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (push && pop) begin
            entries[ptr] <= push_addr;
        end else if (push) begin
            entries[ptr + 1'b1] <= push_addr;
        end
    end

endmodule

`default_nettype wire

//--- src/branch_subsystem.sv
// Branch resolution subsystem top
`default_nettype none

module branch_subsystem
    import branch_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue,
    input  branch_op_e             op,
    input  logic       [31:0]      instr,
    input  logic       [XLEN-1:0]  dec_pc,
    input  logic                   dec_pc_valid,
    input  logic       [XLEN-1:0]  rs1,
    input  logic       [XLEN-1:0]  rs2,
    input  logic                   is_call,
    input  logic                   is_return,
    input  logic                   predicted_taken,
    output logic                   resolve,
    output logic                   taken,
    output logic                   flush,
    output logic       [XLEN-1:0]  target_pc,
    output logic       [XLEN-1:0]  fallthrough_pc,
    output logic       [XLEN-1:0]  ras_top,
    output logic                   ras_valid
);

    logic capture;
    logic cond_taken;
    logic ras_push;
    logic ras_pop;

    branch_resolve_ctrl ctrl0 (
        .clk             (clk),
        .rst             (rst),
        .issue           (issue),
        .op              (op),
        .cond_taken      (cond_taken),
        .is_call         (is_call),
        .is_return       (is_return),
        .predicted_taken (predicted_taken),
        .dec_pc_valid    (dec_pc_valid),
        .dec_pc          (dec_pc),
        .target_pc       (target_pc),
        .fallthrough_pc  (fallthrough_pc),
        .capture         (capture),
        .resolve         (resolve),
        .taken           (taken),
        .flush           (flush),
        .ras_push        (ras_push),
        .ras_pop         (ras_pop)
    );

    branch_comparator cmp0 (
        .op         (op),
        .rs1        (rs1),
        .rs2        (rs2),
        .cond_taken (cond_taken)
    );

    branch_target_calc tgt0 (
        .clk            (clk),
        .rst            (rst),
        .capture        (capture),
        .op             (op),
        .instr          (instr),
        .dec_pc         (dec_pc),
        .rs1            (rs1),
        .target_pc      (target_pc),
        .fallthrough_pc (fallthrough_pc)
    );

    // Calls push their own return address
    return_addr_stack ras0 (
        .clk       (clk),
        .rst       (rst),
        .push      (ras_push),
        .pop       (ras_pop),
        .push_addr (fallthrough_pc),
        .top_addr  (ras_top),
        .not_empty (ras_valid)
    );

endmodule

`default_nettype wire

//--- dv/branch_properties.sv
// Branch stage timing assertions
`default_nettype none

module branch_properties
    import branch_pkg::*;
(
    input logic            clk,
    input logic            rst,
    input logic            capture,
    input logic            dec_pc_valid,
    input logic            is_call,
    input logic            is_return,
    input logic            resolve,
    input logic            taken,
    input logic            flush,
    input logic [XLEN-1:0] dec_pc,
    input logic [XLEN-1:0] target_pc,
    input logic [XLEN-1:0] fallthrough_pc,
    input logic            ras_push,
    input logic            ras_pop
);

    logic pending;
    logic addr_wrong;
    int   resolve_fails = 0;
    int   flush_fails = 0;
    int   stack_fails = 0;
    int   issue_fails = 0;
    int   fail_count;

    assign fail_count = resolve_fails + flush_fails + stack_fails + issue_fails;

    // Branch held from capture until decode valid
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (capture) begin
            pending <= 1'b1;
        end else if (dec_pc_valid) begin
            pending <= 1'b0;
        end
    end

    // Next PC off the real outcome's address, bit 0 ignored
    assign addr_wrong = taken ? (dec_pc[XLEN-1:1] != target_pc[XLEN-1:1])
                              : (dec_pc[XLEN-1:1] != fallthrough_pc[XLEN-1:1]);

    //////////////////////////////////////////////////
    // Timing rules
    //////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst) resolve == (pending && dec_pc_valid))
        else begin
            resolve_fails++;
            $error("resolve not in the first decode valid cycle after capture");
        end

    assert property (@(posedge clk) disable iff (rst) resolve && addr_wrong |-> flush)
        else begin
            flush_fails++;
            $error("wrong next PC at resolve did not raise flush");
        end

    // Stack requests one cycle after a call or return capture
    assert property (@(posedge clk) disable iff (rst)
        (ras_push || ras_pop) == $past(capture && (is_call || is_return)))
        else begin
            stack_fails++;
            $error("stack request not one cycle after capture");
        end

    assert property (@(posedge clk) disable iff (rst) pending |-> !capture)
        else begin
            issue_fails++;
            $error("issue captured while a branch was held");
        end

endmodule

bind branch_subsystem branch_properties props0 (.*);

`default_nettype wire

//--- dv/branch_tb.sv
// Branch subsystem testbench
`default_nettype none

module branch_tb
    import branch_pkg::*;
();

    localparam int NUM_TESTS   = 300;
    localparam int MAX_DELAY   = 7;
    localparam int CALL_DEPTH  = RAS_DEPTH + 2;
    localparam int CYCLE_LIMIT = (NUM_TESTS + 2 * CALL_DEPTH) * (MAX_DELAY + 4) + 50;

    logic        clk;
    logic        rst;
    logic        issue;
    branch_op_e  op;
    logic [31:0] instr;
    logic [31:0] dec_pc;
    logic        dec_pc_valid;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic        is_call;
    logic        is_return;
    logic        predicted_taken;
    logic        resolve;
    logic        taken;
    logic        flush;
    logic [31:0] target_pc;
    logic [31:0] fallthrough_pc;
    logic [31:0] ras_top;
    logic        ras_valid;

    logic [31:0] lfsr;
    logic [31:0] shadow [$];
    int          value_errors = 0;
    int          cycle_count = 0;

    branch_subsystem dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus source and reference model
    //////////////////////////////////////////////////

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] edge_value(input logic [1:0] sel);
        case (sel)
            2'd0:    return 32'h8000_0000;
            2'd1:    return 32'h7fff_ffff;
            2'd2:    return 32'hffff_ffff;
            default: return 32'h0000_0000;
        endcase
    endfunction

    function automatic logic model_taken(input branch_op_e o, input logic [31:0] a,
                                         input logic [31:0] b);
        case (o)
            BR_EQ:   return a == b;
            BR_NE:   return a != b;
            BR_LT:   return $signed(a) < $signed(b);
            BR_GE:   return $signed(a) >= $signed(b);
            BR_LTU:  return a < b;
            BR_GEU:  return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////
    // One branch from issue to stack update
    //////////////////////////////////////////////////

    task automatic run_branch(input branch_op_e o, input logic [31:0] a, input logic [31:0] b,
                              input logic call, input logic ret);
        logic [31:0] raw;
        logic [31:0] fill;
        logic [31:0] ctl;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [31:0] word;
        logic [31:0] exp_target;
        logic [31:0] exp_fall;
        logic [31:0] correct_pc;
        logic [31:0] next_pc;
        logic        exp_taken;
        logic        exp_flush;
        int          delay;
        raw   = take_bits(20);
        fill  = take_bits(32);
        ctl   = take_bits(4);
        pc    = take_bits(30) << 2;
        delay = int'(take_bits(3));

        // Build the instruction word around a chosen offset
        case (o)
            BR_JAL: begin
                imm  = {{11{raw[19]}}, raw[19:0], 1'b0};
                word = {imm[20], imm[10:1], imm[11], imm[19:12], fill[11:0]};
            end
            BR_JALR: begin
                imm  = {{20{raw[11]}}, raw[11:0]};
                word = {imm[11:0], fill[19:0]};
            end
            default: begin
                imm  = {{19{raw[11]}}, raw[11:0], 1'b0};
                word = {imm[12], imm[10:5], fill[19:7], imm[4:1], imm[11], fill[6:0]};
            end
        endcase

        exp_taken  = model_taken(o, a, b);
        exp_target = (((o == BR_JALR) ? a : pc) + imm) & ~32'h1;
        exp_fall   = pc + 32'd4;
        correct_pc = exp_taken ? exp_target : exp_fall;
        case (ctl[2:1])
            2'd2:    next_pc = correct_pc ^ 32'h1;
            2'd3:    next_pc = correct_pc ^ ((take_bits(29) << 3) | 32'h8);
            default: next_pc = correct_pc;
        endcase
        exp_flush = (ctl[0] != exp_taken) || (next_pc[31:1] != correct_pc[31:1]);

        @(negedge clk);
        issue           = 1'b1;
        op              = o;
        instr           = word;
        dec_pc          = pc;
        dec_pc_valid    = 1'b0;
        rs1             = a;
        rs2             = b;
        is_call         = call;
        is_return       = ret;
        predicted_taken = ctl[0];

        // Held cycles, a stray issue in the first one must be ignored
        for (int h = 0; h < delay; h++) begin
            @(negedge clk);
            issue           = (h == 0) && ctl[3];
            is_call         = issue;
            is_return       = 1'b0;
            dec_pc          = ~pc;
            rs1             = ~a;
            predicted_taken = ~ctl[0];
        end
        @(negedge clk);
        issue        = 1'b0;
        is_call      = 1'b0;
        is_return    = 1'b0;
        dec_pc_valid = 1'b1;
        dec_pc       = next_pc;

        @(posedge clk);
        assert (resolve) else begin
            value_errors++;
            $display("Missing resolve for %s branch at pc %h", o.name(), pc);
        end
        check_value({o.name(), " taken"}, 32'(exp_taken), 32'(taken));
        check_value({o.name(), " flush"}, 32'(exp_flush), 32'(flush));
        check_value({o.name(), " target_pc"}, exp_target, target_pc);
        check_value({o.name(), " fallthrough_pc"}, exp_fall, fallthrough_pc);

        @(negedge clk);
        dec_pc_valid = 1'b0;
        if (call) begin
            shadow.push_back(exp_fall);
            if (shadow.size() > RAS_DEPTH) void'(shadow.pop_front());
        end else if (ret && shadow.size() > 0) begin
            void'(shadow.pop_back());
        end

        @(posedge clk);
        check_value("ras_valid", 32'(shadow.size() > 0), 32'(ras_valid));
        if (shadow.size() > 0) check_value("ras_top", shadow[$], ras_top);
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] sel;
        logic [31:0] a;
        logic [31:0] b;
        branch_op_e  o;
        logic        call;
        logic        ret;
        lfsr            = 32'hb78d_fe44;
        rst             = 1'b1;
        issue           = 1'b0;
        op              = BR_EQ;
        instr           = '0;
        dec_pc          = '0;
        dec_pc_valid    = 1'b0;
        rs1             = '0;
        rs2             = '0;
        is_call         = 1'b0;
        is_return       = 1'b0;
        predicted_taken = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Decode valid while idle must not resolve
        dec_pc_valid = 1'b1;

        @(posedge clk);
        check_value("reset resolve", 32'h0, 32'(resolve));
        check_value("reset flush", 32'h0, 32'(flush));
        check_value("reset taken", 32'h0, 32'(taken));
        check_value("reset ras_valid", 32'h0, 32'(ras_valid));

        // Random opcodes, operand styles and stack hints
        for (int t = 0; t < NUM_TESTS; t++) begin
            sel = take_bits(11);
            o   = branch_op_e'(sel[2:0]);
            case (sel[4:3])
                2'd0: begin
                    a = take_bits(32);
                    b = take_bits(32);
                end
                2'd1: begin
                    a = take_bits(32);
                    b = a;
                end
                2'd2: begin
                    a = edge_value(sel[6:5]);
                    b = edge_value(sel[8:7]);
                end
                default: begin
                    a = take_bits(3);
                    b = take_bits(3);
                end
            endcase
            call = sel[9] && (o == BR_JAL || o == BR_JALR);
            ret  = sel[10] && (o == BR_JALR) && !call;
            run_branch(o, a, b, call, ret);
        end

        // Calls past the stack depth, then returns past empty
        for (int c = 0; c < CALL_DEPTH; c++) begin
            run_branch(BR_JAL, take_bits(32), take_bits(32), 1'b1, 1'b0);
        end
        for (int r = 0; r < CALL_DEPTH; r++) begin
            run_branch(BR_JALR, take_bits(32), take_bits(32), 1'b0, 1'b1);
        end

        repeat (2) @(posedge clk);
        $display("Errors: %0d value checks, %0d assertions",
                 value_errors, dut0.props0.fail_count);
        if (value_errors == 0 && dut0.props0.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
src/branch_pkg.sv
src/branch_comparator.sv
src/branch_target_calc.sv
src/branch_resolve_ctrl.sv
src/return_addr_stack.sv
src/branch_subsystem.sv
dv/branch_properties.sv
dv/branch_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := branch_tb
FILELIST   := tb.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
RUN_FLAGS  := +verilator+error+limit+1000
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := *** FAILED ***
PASS_MSG   := *** PASSED ***

.PHONY: all build lint clean

all: build
	-./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation ended early"; exit 1)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
